// File: sources.f
rtl/rsa_pkg.sv
rtl/rsa_wb_slave.sv
rtl/rsa_feeder.sv
rtl/rsa_pe.sv
rtl/rsa_drain.sv
rtl/rsa_top.sv
sim/tb_rsa.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_rsa
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: sim/tb_rsa.sv
`timescale 1ns/10ps

module tb_rsa;
  import rsa_pkg::*;

  localparam int HALF_PERIOD    = 2;
  // all tests take well under two thousand cycles, wide margin on top
  localparam int TIMEOUT_CYCLES = 20000;
  localparam int POLL_LIMIT     = 200;
  localparam int NN             = ARRAY_N * ARRAY_N;
  localparam logic [31:0] SEED  = 32'd89420;

  logic             clk;
  logic             i_reset;
  logic             i_wb_cyc;
  logic             i_wb_stb;
  logic             i_wb_we;
  logic [ADR_W-1:0] i_wb_adr;
  word_t            i_wb_dat;
  word_t            o_wb_dat;
  logic             o_wb_ack;

  // host copies of the operands
  word_t       a_m [NN];
  word_t       b_m [NN];
  // expected accumulator contents, row major
  word_t       c_model [NN];
  logic [31:0] lfsr = SEED;
  int          cycles = 0;

  rsa_top UUT (
    .clk      (clk),
    .i_reset  (i_reset),
    .i_wb_cyc (i_wb_cyc),
    .i_wb_stb (i_wb_stb),
    .i_wb_we  (i_wb_we),
    .i_wb_adr (i_wb_adr),
    .i_wb_dat (i_wb_dat),
    .o_wb_dat (o_wb_dat),
    .o_wb_ack (o_wb_ack)
  );

  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Something failed");
    $fatal(1, "simulation stopped");
  endtask

  // watchdog
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles > TIMEOUT_CYCLES) begin
      fail_run("simulation ran past its cycle limit");
    end
  end

  task automatic check(input string name, input logic [31:0] expected,
                       input logic [31:0] actual);
    if (expected !== actual) begin
      $display("[FAIL] %s expected 0x%0h actual 0x%0h", name, expected, actual);
      fail_run("a checked value did not match");
    end
  endtask

  // galois form, taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic next_bit();
    lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
    return lfsr[0];
  endfunction

  function automatic word_t rand_word();
    word_t w;
    for (int i = 0; i < DATA_W; i++) begin
      w[i] = next_bit();
    end
    return w;
  endfunction

  // one wishbone classic transfer, data sampled mid cycle while ack is high
  task automatic bus_cycle(input logic write, input logic [ADR_W-1:0] addr,
                           input word_t data, output word_t rd);
    @(posedge clk);
    i_wb_cyc <= 1'b1;
    i_wb_stb <= 1'b1;
    i_wb_we  <= write;
    i_wb_adr <= addr;
    i_wb_dat <= data;
    do begin
      @(negedge clk);
    end while (o_wb_ack !== 1'b1);
    rd = o_wb_dat;
    @(posedge clk);
    i_wb_cyc <= 1'b0;
    i_wb_stb <= 1'b0;
    i_wb_we  <= 1'b0;
  endtask

  task automatic wb_write(input logic [ADR_W-1:0] addr, input word_t data);
    word_t unused;
    bus_cycle(1'b1, addr, data, unused);
  endtask

  task automatic wb_read(input logic [ADR_W-1:0] addr, output word_t data);
    bus_cycle(1'b0, addr, '0, data);
  endtask

  task automatic load_operands();
    for (int i = 0; i < NN; i++) begin
      wb_write(A_BASE + ADR_W'(i), a_m[i]);
    end
    for (int i = 0; i < NN; i++) begin
      wb_write(B_BASE + ADR_W'(i), b_m[i]);
    end
  endtask

  // product truncated to 16 bits, sums wrap
  task automatic model_op(input op_e op);
    logic [31:0] full;
    word_t       sum;
    for (int r = 0; r < ARRAY_N; r++) begin
      for (int c = 0; c < ARRAY_N; c++) begin
        sum = '0;
        for (int k = 0; k < ARRAY_N; k++) begin
          full = a_m[r*ARRAY_N + k] * b_m[k*ARRAY_N + c];
          sum  = sum + full[DATA_W-1:0];
        end
        case (op)
          OP_MUL:     c_model[r*ARRAY_N + c] = sum;
          OP_MAC_ADD: c_model[r*ARRAY_N + c] = c_model[r*ARRAY_N + c] + sum;
          default:    c_model[r*ARRAY_N + c] = c_model[r*ARRAY_N + c] - sum;
        endcase
      end
    end
  endtask

  task automatic wait_idle();
    word_t st;
    int    polls;
    polls = 0;
    do begin
      polls++;
      if (polls > POLL_LIMIT) begin
        fail_run("busy never dropped while polling status");
      end
      wb_read(STAT_ADR, st);
    end while (st[0]);
  endtask

  task automatic check_c(input string name);
    word_t d;
    for (int i = 0; i < NN; i++) begin
      wb_read(C_BASE + ADR_W'(i), d);
      check($sformatf("%s C[%0d]", name, i), c_model[i], d);
    end
  endtask

  task automatic run_op(input op_e op);
    wb_write(CTRL_ADR, word_t'(op));
    wait_idle();
    model_op(op);
  endtask

  task automatic randomize_operands();
    for (int i = 0; i < NN; i++) begin
      a_m[i] = rand_word();
      b_m[i] = rand_word();
    end
  endtask

  task automatic test_reset();
    word_t st;
    wb_read(STAT_ADR, st);
    check("reset status", 0, st);
    check_c("reset");
  endtask

  task automatic test_mul();
    word_t st;
    word_t d;
    // identity B, C comes back as A
    for (int i = 0; i < NN; i++) begin
      a_m[i] = rand_word();
      b_m[i] = (i / ARRAY_N == i % ARRAY_N) ? 16'd1 : 16'd0;
    end
    load_operands();
    run_op(OP_MUL);
    for (int i = 0; i < NN; i++) begin
      wb_read(C_BASE + ADR_W'(i), d);
      check($sformatf("mul identity C[%0d]", i), a_m[i], d);
    end
    randomize_operands();
    load_operands();
    run_op(OP_MUL);
    check_c("mul random");
    wb_read(STAT_ADR, st);
    check("mul status", 2, st);
  endtask

  task automatic test_mac_add();
    randomize_operands();
    load_operands();
    run_op(OP_MAC_ADD);
    check_c("mac add");
  endtask

  task automatic test_mac_sub();
    // negative A against positive B drives sums through the wrap
    for (int i = 0; i < NN; i++) begin
      a_m[i] = rand_word() | 16'h8000;
      b_m[i] = rand_word() & 16'h7fff;
    end
    load_operands();
    run_op(OP_MAC_SUB);
    check_c("mac sub");
  endtask

  task automatic test_busy();
    word_t prev [NN];
    word_t d;
    prev = c_model;
    randomize_operands();
    load_operands();
    wb_write(CTRL_ADR, word_t'(OP_MUL));
    // second start lands inside the busy window and is dropped
    wb_write(CTRL_ADR, word_t'(OP_MAC_ADD));
    wb_read(STAT_ADR, d);
    check("busy status", 1, d);
    wb_read(C_BASE, d);
    check("busy C[0]", prev[0], d);
    wb_read(C_BASE + ADR_W'(NN - 1), d);
    check("busy C[last]", prev[NN-1], d);
    wait_idle();
    model_op(OP_MUL);
    check_c("busy single op");
    // reserved opcode starts nothing, done stays set
    wb_write(CTRL_ADR, 16'd3);
    wb_read(STAT_ADR, d);
    check("opcode 3 status", 2, d);
    check_c("opcode 3");
  endtask

  initial begin
    i_reset  = 1'b1;
    i_wb_cyc = 1'b0;
    i_wb_stb = 1'b0;
    i_wb_we  = 1'b0;
    i_wb_adr = '0;
    i_wb_dat = '0;
    for (int i = 0; i < NN; i++) begin
      c_model[i] = '0;
    end
    repeat (3) @(posedge clk);
    i_reset <= 1'b0;
    test_reset();
    test_mul();
    test_mac_add();
    test_mac_sub();
    test_busy();
    $display("Everything OK");
    $finish;
  end

endmodule

// File: rtl/rsa_top.sv
`timescale 1ns/10ps

module rsa_top (
  input  logic                      clk,
  input  logic                      i_reset,
  input  logic                      i_wb_cyc,
  input  logic                      i_wb_stb,
  input  logic                      i_wb_we,
  input  logic [rsa_pkg::ADR_W-1:0] i_wb_adr,
  input  rsa_pkg::word_t            i_wb_dat,
  output rsa_pkg::word_t            o_wb_dat,
  output logic                      o_wb_ack
);
  import rsa_pkg::*;

  // slave to feeder and drain
  logic                                   op_wr;
  logic [$clog2(2*ARRAY_N*ARRAY_N)-1:0]   op_adr;
  word_t                                  op_dat;
  logic                                   start;
  op_e                                    op;
  logic                                   busy;
  logic [$clog2(ARRAY_N*ARRAY_N)-1:0]     rd_idx;
  word_t                                  rd_data;
  logic                                   drain_done;

  // array edges and controls
  word_t                                  a_row [ARRAY_N];
  logic [ARRAY_N-1:0]                     a_vld;
  word_t                                  b_col [ARRAY_N];
  logic [ARRAY_N-1:0]                     b_vld;
  logic                                   clear;
  logic                                   sub;
  logic                                   shift;

  // PE outputs, [row][column]
  word_t                                  a_out     [ARRAY_N][ARRAY_N];
  logic                                   a_out_vld [ARRAY_N][ARRAY_N];
  word_t                                  b_out     [ARRAY_N][ARRAY_N];
  logic                                   b_out_vld [ARRAY_N][ARRAY_N];
  word_t                                  c_out     [ARRAY_N][ARRAY_N];
  word_t                                  row_c     [ARRAY_N];

  rsa_wb_slave u_wb_slave (
    .clk       (clk),
    .i_reset   (i_reset),
    .i_wb_cyc  (i_wb_cyc),
    .i_wb_stb  (i_wb_stb),
    .i_wb_we   (i_wb_we),
    .i_wb_adr  (i_wb_adr),
    .i_wb_dat  (i_wb_dat),
    .i_busy    (busy),
    .i_rd_data (rd_data),
    .o_wb_dat  (o_wb_dat),
    .o_wb_ack  (o_wb_ack),
    .o_op_wr   (op_wr),
    .o_op_adr  (op_adr),
    .o_op_dat  (op_dat),
    .o_start   (start),
    .o_op      (op),
    .o_rd_idx  (rd_idx)
  );

  rsa_feeder u_feeder (
    .clk          (clk),
    .i_reset      (i_reset),
    .i_op_wr      (op_wr),
    .i_op_adr     (op_adr),
    .i_op_dat     (op_dat),
    .i_start      (start),
    .i_op         (op),
    .i_drain_done (drain_done),
    .o_busy       (busy),
    .o_a_row      (a_row),
    .o_a_vld      (a_vld),
    .o_b_col      (b_col),
    .o_b_vld      (b_vld),
    .o_clear      (clear),
    .o_sub        (sub),
    .o_shift      (shift)
  );

  // PE grid
  // row 0 is the south edge, column 0 the west edge
  for (genvar r = 0; r < ARRAY_N; r++) begin : g_row
    for (genvar c = 0; c < ARRAY_N; c++) begin : g_col
      word_t a_in;
      logic  a_in_vld;
      word_t b_in;
      logic  b_in_vld;
      word_t east_c;

      // A from the feeder or the west neighbour
      if (c == 0) begin : g_a_edge
        assign a_in     = a_row[r];
        assign a_in_vld = a_vld[r];
      end else begin : g_a_chain
        assign a_in     = a_out[r][c-1];
        assign a_in_vld = a_out_vld[r][c-1];
      end

      // B from the feeder or the south neighbour
      if (r == 0) begin : g_b_edge
        assign b_in     = b_col[c];
        assign b_in_vld = b_vld[c];
      end else begin : g_b_chain
        assign b_in     = b_out[r-1][c];
        assign b_in_vld = b_out_vld[r-1][c];
      end

      // last column wraps to column 0 so the shift is a rotation
      if (c == ARRAY_N - 1) begin : g_c_wrap
        assign east_c = c_out[r][0];
      end else begin : g_c_chain
        assign east_c = c_out[r][c+1];
      end

      rsa_pe u_pe (
        .clk      (clk),
        .i_reset  (i_reset),
        .i_a      (a_in),
        .i_a_vld  (a_in_vld),
        .i_b      (b_in),
        .i_b_vld  (b_in_vld),
        .i_clear  (clear),
        .i_sub    (sub),
        .i_shift  (shift),
        .i_east_c (east_c),
        .o_a      (a_out[r][c]),
        .o_a_vld  (a_out_vld[r][c]),
        .o_b      (b_out[r][c]),
        .o_b_vld  (b_out_vld[r][c]),
        .o_c      (c_out[r][c])
      );
    end

    // column 0 drains west
    assign row_c[r] = c_out[r][0];
  end

  rsa_drain u_drain (
    .clk       (clk),
    .i_reset   (i_reset),
    .i_shift   (shift),
    .i_row_c   (row_c),
    .i_rd_idx  (rd_idx),
    .o_done    (drain_done),
    .o_rd_data (rd_data)
  );

endmodule

// File: rtl/rsa_drain.sv
`timescale 1ns/10ps

module rsa_drain (
  input  logic                                                 clk,
  input  logic                                                 i_reset,
  input  logic                                                 i_shift,
  input  rsa_pkg::word_t                                       i_row_c [rsa_pkg::ARRAY_N],
  input  logic [$clog2(rsa_pkg::ARRAY_N*rsa_pkg::ARRAY_N)-1:0] i_rd_idx,
  output logic                                                 o_done,
  output rsa_pkg::word_t                                       o_rd_data
);
  import rsa_pkg::*;

  // column that sits in column 0 during this shift
  logic [$clog2(ARRAY_N)-1:0] shift_cnt;
  logic                       last_shift;

  // shadow fills during the drain, visible is what the host reads
  word_t                      shadow  [ARRAY_N*ARRAY_N];
  word_t                      visible [ARRAY_N*ARRAY_N];

  assign last_shift = i_shift && (int'(shift_cnt) == ARRAY_N - 1);
  assign o_done     = last_shift;

  always_ff @(posedge clk) begin
    if (i_reset) begin
      shift_cnt <= '0;
    end else if (i_shift) begin
      shift_cnt <= last_shift ? '0 : shift_cnt + 1'b1;
    end
  end

  // one column per shift, all rows in parallel
  always_ff @(posedge clk) begin
    if (i_shift) begin
      for (int r = 0; r < ARRAY_N; r++) begin
        shadow[r*ARRAY_N + int'(shift_cnt)] <= i_row_c[r];
      end
    end
  end

  // commit on the last shift
  // last column comes straight from the array
  always_ff @(posedge clk) begin
    if (i_reset) begin
      for (int i = 0; i < ARRAY_N*ARRAY_N; i++) begin
        visible[i] <= '0;
      end
    end else if (last_shift) begin
      for (int r = 0; r < ARRAY_N; r++) begin
        for (int c = 0; c < ARRAY_N; c++) begin
          visible[r*ARRAY_N + c] <= (c == ARRAY_N - 1) ? i_row_c[r] : shadow[r*ARRAY_N + c];
        end
      end
    end
  end

  // host sees the previous result until the commit
  assign o_rd_data = visible[i_rd_idx];

endmodule

// File: rtl/rsa_pe.sv
`timescale 1ns/10ps

module rsa_pe (
  input  logic           clk,
  input  logic           i_reset,
  input  rsa_pkg::word_t i_a,
  input  logic           i_a_vld,
  input  rsa_pkg::word_t i_b,
  input  logic           i_b_vld,
  input  logic           i_clear,
  input  logic           i_sub,
  input  logic           i_shift,
  input  rsa_pkg::word_t i_east_c,
  output rsa_pkg::word_t o_a,
  output logic           o_a_vld,
  output rsa_pkg::word_t o_b,
  output logic           o_b_vld,
  output rsa_pkg::word_t o_c
);
  import rsa_pkg::*;

  word_t acc;
  word_t prod;
  logic  mac_en;

  // low half of the product only, sums wrap
  assign prod   = i_a * i_b;
  assign mac_en = i_a_vld && i_b_vld;

  // valid flags travel with the operands
  always_ff @(posedge clk) begin
    if (i_reset) begin
      o_a_vld <= 1'b0;
      o_b_vld <= 1'b0;
    end else begin
      o_a_vld <= i_a_vld;
      o_b_vld <= i_b_vld;
    end
  end

  // A goes east, B goes north
  always_ff @(posedge clk) begin
    o_a <= i_a;
    o_b <= i_b;
  end

  // accumulator
  // shift takes the east neighbour and rotates the row toward column 0
  always_ff @(posedge clk) begin
    if (i_reset) begin
      acc <= '0;
    end else if (i_clear) begin
      acc <= '0;
    end else if (i_shift) begin
      acc <= i_east_c;
    end else if (mac_en) begin
      acc <= i_sub ? (acc - prod) : (acc + prod);
    end
  end

  assign o_c = acc;

  // the skew must be empty before results move
  a_no_mac_on_shift: assert property (@(posedge clk) disable iff (i_reset)
    i_shift |-> !mac_en);

endmodule

// File: rtl/rsa_feeder.sv
`timescale 1ns/10ps

module rsa_feeder (
  input  logic                                                  clk,
  input  logic                                                  i_reset,
  input  logic                                                  i_op_wr,
  input  logic [$clog2(2*rsa_pkg::ARRAY_N*rsa_pkg::ARRAY_N)-1:0] i_op_adr,
  input  rsa_pkg::word_t                                        i_op_dat,
  input  logic                                                  i_start,
  input  rsa_pkg::op_e                                          i_op,
  input  logic                                                  i_drain_done,
  output logic                                                  o_busy,
  output rsa_pkg::word_t                                        o_a_row [rsa_pkg::ARRAY_N],
  output logic [rsa_pkg::ARRAY_N-1:0]                           o_a_vld,
  output rsa_pkg::word_t                                        o_b_col [rsa_pkg::ARRAY_N],
  output logic [rsa_pkg::ARRAY_N-1:0]                           o_b_vld,
  output logic                                                  o_clear,
  output logic                                                  o_sub,
  output logic                                                  o_shift
);
  import rsa_pkg::*;

  seq_state_e                         state;
  logic [$clog2(FEED_CYCLES)-1:0]     feed_cnt;

  // operand memories, row major
  word_t                              a_mem [ARRAY_N*ARRAY_N];
  word_t                              b_mem [ARRAY_N*ARRAY_N];

  // host write decode
  logic [ADR_W-1:0]                   wr_adr;
  logic [ADR_W-1:0]                   wr_off;
  logic                               wr_is_a;

  assign wr_adr  = ADR_W'(i_op_adr);
  assign wr_is_a = wr_adr < B_BASE;
  assign wr_off  = wr_is_a ? (wr_adr - A_BASE) : (wr_adr - B_BASE);

  always_ff @(posedge clk) begin
    if (i_op_wr) begin
      if (wr_is_a) begin
        a_mem[wr_off[$clog2(ARRAY_N*ARRAY_N)-1:0]] <= i_op_dat;
      end else begin
        b_mem[wr_off[$clog2(ARRAY_N*ARRAY_N)-1:0]] <= i_op_dat;
      end
    end
  end

  // sequencer
  // clear only for a plain multiply, accumulate modes keep C in the PEs
  always_ff @(posedge clk) begin
    if (i_reset) begin
      state    <= S_IDLE;
      feed_cnt <= '0;
      o_sub    <= 1'b0;
    end else begin
      case (state)
        S_IDLE: begin
          feed_cnt <= '0;
          if (i_start) begin
            o_sub <= (i_op == OP_MAC_SUB);
            state <= (i_op == OP_MUL) ? S_CLEAR : S_FEED;
          end
        end
        S_CLEAR: begin
          state <= S_FEED;
        end
        S_FEED: begin
          feed_cnt <= feed_cnt + 1'b1;
          if (int'(feed_cnt) == FEED_CYCLES - 1) begin
            state <= S_FLUSH;
          end
        end
        // last MAC lands in the corner PE here
        S_FLUSH: begin
          state <= S_DRAIN;
        end
        // shift stays up until the drain has seen every column
        S_DRAIN: begin
          if (i_drain_done) begin
            state <= S_IDLE;
            o_sub <= 1'b0;
          end
        end
        default: begin
          state <= S_IDLE;
        end
      endcase
    end
  end

  assign o_busy  = (state != S_IDLE);
  assign o_clear = (state == S_CLEAR);
  assign o_shift = (state == S_DRAIN);

  // skewed edge feed
  // row r gets A[r][t-r], column c gets B[t-c][c]
  always_comb begin
    int                          t;
    logic [$clog2(ARRAY_N)-1:0]  k;
    t = int'(feed_cnt);
    for (int i = 0; i < ARRAY_N; i++) begin
      k          = ($clog2(ARRAY_N))'(t - i);
      o_a_vld[i] = (state == S_FEED) && (t >= i) && (t < i + ARRAY_N);
      o_b_vld[i] = o_a_vld[i];
      // idle edges stay at zero
      o_a_row[i] = o_a_vld[i] ? a_mem[i*ARRAY_N + int'(k)] : '0;
      o_b_col[i] = o_b_vld[i] ? b_mem[int'(k)*ARRAY_N + i] : '0;
    end
  end

  // shift belongs to the drain phase only
  a_shift_state: assert property (@(posedge clk) disable iff (i_reset)
    (o_shift || i_drain_done) |-> state == S_DRAIN);

  // drain answers after exactly one shift per column
  a_drain_len: assert property (@(posedge clk) disable iff (i_reset)
    $rose(o_shift) |-> ##(ARRAY_N - 1) (o_shift && i_drain_done));

endmodule

// File: rtl/rsa_wb_slave.sv
`timescale 1ns/10ps

module rsa_wb_slave (
  input  logic                                                clk,
  input  logic                                                i_reset,
  input  logic                                                i_wb_cyc,
  input  logic                                                i_wb_stb,
  input  logic                                                i_wb_we,
  input  logic [rsa_pkg::ADR_W-1:0]                           i_wb_adr,
  input  rsa_pkg::word_t                                      i_wb_dat,
  input  logic                                                i_busy,
  input  rsa_pkg::word_t                                      i_rd_data,
  output rsa_pkg::word_t                                      o_wb_dat,
  output logic                                                o_wb_ack,
  output logic                                                o_op_wr,
  output logic [$clog2(2*rsa_pkg::ARRAY_N*rsa_pkg::ARRAY_N)-1:0] o_op_adr,
  output rsa_pkg::word_t                                      o_op_dat,
  output logic                                                o_start,
  output rsa_pkg::op_e                                        o_op,
  output logic [$clog2(rsa_pkg::ARRAY_N*rsa_pkg::ARRAY_N)-1:0] o_rd_idx
);
  import rsa_pkg::*;

  // registered request
  logic             req_we;
  logic [ADR_W-1:0] req_adr;
  word_t            req_dat;
  logic [ADR_W-1:0] req_c_off;

  // decode of the registered request
  logic             accept;
  logic             in_c;
  logic             ctrl_wr;

  // sticky done tracking
  logic             busy_q;
  logic             done_q;
  logic             done_now;

  // new request only while ack is low
  // gives one ack every two cycles under a held stb
  assign accept = i_wb_cyc && i_wb_stb && !o_wb_ack;

  always_ff @(posedge clk) begin
    if (i_reset) begin
      o_wb_ack <= 1'b0;
    end else begin
      o_wb_ack <= accept;
    end
  end

  // request payload
  always_ff @(posedge clk) begin
    if (accept) begin
      req_we  <= i_wb_we;
      req_adr <= i_wb_adr;
      req_dat <= i_wb_dat;
    end
  end

  // everything below acts in the ack cycle
  assign in_c      = (req_adr >= C_BASE) && (req_adr < CTRL_ADR);
  assign ctrl_wr   = o_wb_ack && req_we && (req_adr == CTRL_ADR);
  assign req_c_off = req_adr - C_BASE;

  // operand writes, A and B share one flat range below C
  assign o_op_wr  = o_wb_ack && req_we && (req_adr < C_BASE);
  assign o_op_adr = req_adr[$clog2(2*ARRAY_N*ARRAY_N)-1:0];
  assign o_op_dat = req_dat;

  // start pulse, dropped while busy or for the reserved opcode
  assign o_op    = op_e'(req_dat[1:0]);
  assign o_start = ctrl_wr && !i_busy && (o_op inside {OP_MUL, OP_MAC_ADD, OP_MAC_SUB});

  // C element select toward the drain
  assign o_rd_idx = req_c_off[$clog2(ARRAY_N*ARRAY_N)-1:0];

  // done sets on the falling edge of busy
  always_ff @(posedge clk) begin
    if (i_reset) begin
      busy_q <= 1'b0;
      done_q <= 1'b0;
    end else begin
      busy_q <= i_busy;
      if (o_start) begin
        done_q <= 1'b0;
      end else if (busy_q && !i_busy) begin
        done_q <= 1'b1;
      end
    end
  end

  // first idle cycle already reports done
  assign done_now = done_q || (busy_q && !i_busy);

  // read mux
  // A, B and unmapped words read as zero
  always_comb begin
    o_wb_dat = '0;
    if (in_c) begin
      o_wb_dat = i_rd_data;
    end else if (req_adr == STAT_ADR) begin
      o_wb_dat[1:0] = {done_now, i_busy};
    end
  end

  // one wait state, never back to back acks
  a_ack_gap: assert property (@(posedge clk) disable iff (i_reset)
    o_wb_ack |=> !o_wb_ack);

  // feeder has to pick up every accepted start
  a_start_busy: assert property (@(posedge clk) disable iff (i_reset)
    o_start |=> i_busy);

endmodule

// File: rtl/rsa_pkg.sv
package rsa_pkg;

  // array geometry
  // ARRAY_N is also the inner dimension of the product
  localparam int ARRAY_N = 4;
  localparam int DATA_W  = 16;
  localparam int ADR_W   = 6;

  // one matrix element, 16 bit two's complement
  typedef logic [DATA_W-1:0] word_t;

  // word addresses on the host bus
  // element [r][c] sits at base + r*ARRAY_N + c
  localparam logic [ADR_W-1:0] A_BASE   = ADR_W'(0);
  localparam logic [ADR_W-1:0] B_BASE   = ADR_W'(16);
  localparam logic [ADR_W-1:0] C_BASE   = ADR_W'(32);

  // control write starts an operation, opcode in data bits 1:0
  localparam logic [ADR_W-1:0] CTRL_ADR = ADR_W'(48);
  // status bit 0 busy, bit 1 done
  localparam logic [ADR_W-1:0] STAT_ADR = ADR_W'(49);

  // opcode 3 is reserved and ignored by the slave
  typedef enum logic [1:0] {
    OP_MUL     = 2'd0,
    OP_MAC_ADD = 2'd1,
    OP_MAC_SUB = 2'd2
  } op_e;

  // sequencer states
  typedef enum logic [2:0] {
    S_IDLE,
    S_CLEAR,
    S_FEED,
    S_FLUSH,
    S_DRAIN
  } seq_state_e;

  // skew length, last operand pair meets in the far corner PE
  localparam int FEED_CYCLES = 3 * ARRAY_N - 2;

endpackage
